//--- hw/fetch_pkg.sv
package fetch_pkg;

    // Byte address of an instruction, low two bits always zero
    typedef logic [31:0] pc_t;

    // Two-bit branch history counter, lower values lean toward taken
    typedef logic [1:0] hist_t;

    localparam hist_t HIST_STRONG_TAKEN = 2'd0;
    localparam hist_t HIST_TAKEN = 2'd1;
    localparam hist_t HIST_NOT_TAKEN = 2'd2;
    localparam hist_t HIST_STRONG_NOT_TAKEN = 2'd3;

    // Width of the redirect epoch count carried as jump_flag
    localparam int EPOCH_WIDTH = 2;

    typedef logic [EPOCH_WIDTH-1:0] epoch_t;

    typedef struct packed {
        logic miss;
        hist_t history;
    } prediction_t;

    // Resolved control transfer reported back by execute
    typedef struct packed {
        pc_t current_pc;
        pc_t actual_next_pc;
        logic update_pc;
        logic branched;
        logic jumped;
        prediction_t prediction;
    } jump_op_t;

    // Command sent to decode for each fetched instruction
    typedef struct packed {
        pc_t pc;
        pc_t next_pc;
        epoch_t jump_flag;
        prediction_t prediction;
    } inst_op_t;

    // Counter values 0 and 1 predict taken
    function automatic logic hist_predicts_taken(input hist_t history);
        return history < HIST_NOT_TAKEN;
    endfunction

endpackage

//--- hw/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer
    import fetch_pkg::*;
#(
    parameter pc_t START_ADDR = 32'h0
)(
    input logic clk,
    input logic rst,

    output pc_t lookup_pc,

    input logic hit,
    input logic is_jump,
    input pc_t target,
    input hist_t counter,

    input logic jump_valid,
    input jump_op_t jump_op,

    output logic cmd_valid,
    input logic cmd_ready,
    output inst_op_t cmd,

    output logic mem_valid,
    input logic mem_ready,
    output pc_t mem_addr
);

    pc_t pc;
    epoch_t epoch;
    logic out_valid;

    logic advance;
    logic redirect;
    logic predict_taken;
    pc_t next_pc;

    // Both streams carry the same pc so they move together
    assign advance = out_valid && cmd_ready && mem_ready;
    assign redirect = jump_valid && jump_op.update_pc;

    assign lookup_pc = pc;

    // Jumps always follow the table, branches only when the counter leans taken
    assign predict_taken = hit && (is_jump || hist_predicts_taken(counter));
    assign next_pc = predict_taken ? target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= START_ADDR;
            epoch <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b1;
            if (redirect) begin
                // Redirect wins over back-pressure
                pc <= jump_op.actual_next_pc;
                epoch <= epoch + 1'b1;
            end else if (advance) begin
                pc <= next_pc;
            end
        end
    end

    assign cmd_valid = out_valid;
    assign mem_valid = out_valid;

    assign cmd.pc = pc;
    assign cmd.next_pc = next_pc;
    assign cmd.jump_flag = epoch;
    assign cmd.prediction.miss = !hit;
    assign cmd.prediction.history = counter;

    assign mem_addr = pc;

    pc_word_aligned: assert property (
        @(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00
    ) else $error("fetch_sequencer: pc %h is not word aligned", pc);

    // A jump report may retrain or redirect, so only quiet stalls are checked
    cmd_stable_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready && !jump_valid |=> $stable(cmd)
    ) else $error("fetch_sequencer: cmd changed while stalled");

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*;
#(
    parameter pc_t START_ADDR = 32'h0,
    parameter int TABLE_ADDR_WIDTH = 4
)(
    input logic clk,
    input logic rst,

    input logic jump_valid,
    input jump_op_t jump_op,

    output logic cmd_valid,
    input logic cmd_ready,
    output inst_op_t cmd,

    output logic mem_valid,
    input logic mem_ready,
    output pc_t mem_addr
);

    pc_t lookup_pc;
    logic hit;
    logic is_jump;
    pc_t target;
    hist_t counter;

    // Both tables train on every jump report from execute
    target_table #(
        .TABLE_ADDR_WIDTH(TABLE_ADDR_WIDTH)
    ) target_table0 (
        .clk(clk),
        .rst(rst),
        .lookup_pc(lookup_pc),
        .hit(hit),
        .target(target),
        .is_jump(is_jump),
        .train_valid(jump_valid),
        .train(jump_op)
    );

    history_table #(
        .TABLE_ADDR_WIDTH(TABLE_ADDR_WIDTH)
    ) history_table0 (
        .clk(clk),
        .rst(rst),
        .lookup_pc(lookup_pc),
        .counter(counter),
        .train_valid(jump_valid),
        .train(jump_op)
    );

    fetch_sequencer #(
        .START_ADDR(START_ADDR)
    ) sequencer0 (
        .clk(clk),
        .rst(rst),
        .lookup_pc(lookup_pc),
        .hit(hit),
        .is_jump(is_jump),
        .target(target),
        .counter(counter),
        .jump_valid(jump_valid),
        .jump_op(jump_op),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd(cmd),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready),
        .mem_addr(mem_addr)
    );

endmodule

//--- hw/history_table.sv
`timescale 1ns/1ps

module history_table
    import fetch_pkg::*;
#(
    parameter int TABLE_ADDR_WIDTH = 4
)(
    input logic clk,
    input logic rst,

    input pc_t lookup_pc,
    output hist_t counter,

    input logic train_valid,
    input jump_op_t train
);

    typedef logic [TABLE_ADDR_WIDTH-1:0] index_t;

    index_t read_index;
    index_t write_index;
    hist_t write_counter;

    // Step one place per outcome, saturating at both ends
    function automatic hist_t step_history(input hist_t history, input logic branched);
        hist_t result;
        result = history;
        if (branched) begin
            if (history != HIST_STRONG_TAKEN) begin
                result = history - 2'd1;
            end
        end else begin
            if (history != HIST_STRONG_NOT_TAKEN) begin
                result = history + 2'd1;
            end
        end
        return result;
    endfunction

    assign read_index = lookup_pc[TABLE_ADDR_WIDTH+1:2];
    assign write_index = train.current_pc[TABLE_ADDR_WIDTH+1:2];

    always_comb begin
        if (train.prediction.miss) begin
            // First sighting starts one step off the strong end
            write_counter = train.branched ? HIST_TAKEN : HIST_NOT_TAKEN;
        end else begin
            write_counter = step_history(train.prediction.history, train.branched);
        end
    end

    pred_ram #(
        .entry_t(hist_t),
        .ADDR_WIDTH(TABLE_ADDR_WIDTH)
    ) ram0 (
        .clk(clk),
        .rst(rst),
        .we(train_valid),
        .waddr(write_index),
        .wdata(write_counter),
        .raddr(read_index),
        .rdata(counter)
    );

endmodule

//--- hw/pred_ram.sv
`timescale 1ns/1ps

module pred_ram #(
    parameter type entry_t = logic [7:0],
    parameter int ADDR_WIDTH = 4
)(
    input logic clk,
    input logic rst,

    input logic we,
    input logic [ADDR_WIDTH-1:0] waddr,
    input entry_t wdata,

    input logic [ADDR_WIDTH-1:0] raddr,
    output entry_t rdata
);

    localparam int DEPTH = 2**ADDR_WIDTH;

    entry_t mem [DEPTH];

    // Contents are left as they are through reset
    // but no new write lands while reset is held
    always_ff @(posedge clk) begin
        if (we && !rst) begin
            mem[waddr] <= wdata;
        end
    end

    // Combinational read port
    assign rdata = mem[raddr];

endmodule

//--- hw/target_table.sv
`timescale 1ns/1ps

module target_table
    import fetch_pkg::*;
#(
    parameter int TABLE_ADDR_WIDTH = 4
)(
    input logic clk,
    input logic rst,

    input pc_t lookup_pc,
    output logic hit,
    output pc_t target,
    output logic is_jump,

    input logic train_valid,
    input jump_op_t train
);

    localparam int TAG_WIDTH = $bits(pc_t) - TABLE_ADDR_WIDTH - 2;
    localparam int DEPTH = 2**TABLE_ADDR_WIDTH;

    typedef logic [TABLE_ADDR_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;

    typedef struct packed {
        pc_t target;
        tag_t tag;
        logic is_jump;
    } target_entry_t;

    logic [DEPTH-1:0] entry_valid;

    index_t read_index;
    index_t write_index;
    target_entry_t read_entry;
    target_entry_t write_entry;

    assign read_index = lookup_pc[TABLE_ADDR_WIDTH+1:2];
    assign write_index = train.current_pc[TABLE_ADDR_WIDTH+1:2];

    // Every resolved transfer is recorded, taken or not
    assign write_entry.target = train.actual_next_pc;
    assign write_entry.tag = train.current_pc[31:TABLE_ADDR_WIDTH+2];
    assign write_entry.is_jump = train.jumped;

    pred_ram #(
        .entry_t(target_entry_t),
        .ADDR_WIDTH(TABLE_ADDR_WIDTH)
    ) ram0 (
        .clk(clk),
        .rst(rst),
        .we(train_valid),
        .waddr(write_index),
        .wdata(write_entry),
        .raddr(read_index),
        .rdata(read_entry)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (train_valid) begin
            entry_valid[write_index] <= 1'b1;
        end
    end

    // Aliased PCs sharing an index are told apart by the tag
    assign hit = entry_valid[read_index] &&
            (read_entry.tag == lookup_pc[31:TABLE_ADDR_WIDTH+2]);
    assign target = read_entry.target;
    assign is_jump = read_entry.is_jump;

    // Execute only reports addresses that fetch produced
    train_pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        train_valid |-> (train.current_pc[1:0] == 2'b00)
    ) else $error("target_table: misaligned training pc %h", train.current_pc);

endmodule

//--- run_sim.sh
#!/bin/bash
# Build the fetch unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module fetch_tb -Mdir obj_dir -o fetch_tb \
    && ./obj_dir/fetch_tb 2>&1 | tee sim.log \
    || echo "Build or simulation exited with an error"
if [ ! -s sim.log ] || grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation passed"

//--- sim/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
();

    localparam pc_t START_ADDR = 32'h0000_1000;
    localparam int TABLE_ADDR_WIDTH = 4;
    localparam int DEPTH = 2**TABLE_ADDR_WIDTH;
    localparam int TAG_LSB = TABLE_ADDR_WIDTH + 2;
    // Well above the few hundred cycles the scenarios take under back-pressure
    localparam int TIMEOUT_CYCLES = 3000;

    // Redirect reports come from index 15 at a pc that is never fetched
    localparam pc_t REDIRECT_SRC = 32'h0000_303c;
    localparam pc_t BRANCH_PC = 32'h0000_1040;
    localparam pc_t BRANCH_TARGET = 32'h0000_1100;
    localparam pc_t JUMP_PC = 32'h0000_1010;
    // Same index as BRANCH_PC with another tag
    localparam pc_t JUMP_TARGET = 32'h0000_1080;
    localparam prediction_t MISS_PRED = '{1'b1, HIST_NOT_TAKEN};

    logic clk;
    logic rst;
    logic jump_valid;
    jump_op_t jump_op;
    logic cmd_valid;
    logic cmd_ready;
    inst_op_t cmd;
    logic mem_valid;
    logic mem_ready;
    pc_t mem_addr;

    int seed = 32'h9cfd_c3d2;
    logic [31:0] rnd;
    logic backpressure;
    int cycle = 0;

    // Reference model of both tables and of the fetch PC
    logic [DEPTH-1:0] m_valid;
    logic [31-TAG_LSB:0] m_tag [DEPTH];
    pc_t m_target [DEPTH];
    logic [DEPTH-1:0] m_jump;
    hist_t m_hist [DEPTH];
    pc_t model_pc;
    epoch_t model_epoch;
    logic model_valid;
    logic [TABLE_ADDR_WIDTH-1:0] exp_idx;
    logic [TABLE_ADDR_WIDTH-1:0] train_idx;
    logic exp_hit;
    hist_t exp_hist;
    pc_t exp_next_pc;

    fetch_unit #(
        .START_ADDR(START_ADDR),
        .TABLE_ADDR_WIDTH(TABLE_ADDR_WIDTH)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .jump_valid(jump_valid),
        .jump_op(jump_op),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd(cmd),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready),
        .mem_addr(mem_addr)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // First sighting sets a weak counter and later outcomes step it with saturation
    function automatic hist_t trained_counter(input prediction_t pred, input logic branched);
        hist_t result;
        if (pred.miss) begin
            result = branched ? HIST_TAKEN : HIST_NOT_TAKEN;
        end else if (branched) begin
            result = (pred.history == 2'd0) ? 2'd0 : pred.history - 2'd1;
        end else begin
            result = (pred.history == 2'd3) ? 2'd3 : pred.history + 2'd1;
        end
        return result;
    endfunction

    always_comb begin
        exp_idx = model_pc[TAG_LSB-1:2];
        exp_hit = m_valid[exp_idx] && (m_tag[exp_idx] == model_pc[31:TAG_LSB]);
        exp_hist = m_hist[exp_idx];
        if (exp_hit && (m_jump[exp_idx] || exp_hist < 2'd2)) begin
            exp_next_pc = m_target[exp_idx];
        end else begin
            exp_next_pc = model_pc + 32'd4;
        end
    end

    assign train_idx = jump_op.current_pc[TAG_LSB-1:2];

    always @(posedge clk) begin
        if (rst) begin
            model_pc <= START_ADDR;
            model_epoch <= '0;
            model_valid <= 1'b0;
            m_valid <= '0;
        end else begin
            model_valid <= 1'b1;
            if (jump_valid) begin
                m_valid[train_idx] <= 1'b1;
                m_tag[train_idx] <= jump_op.current_pc[31:TAG_LSB];
                m_target[train_idx] <= jump_op.actual_next_pc;
                m_jump[train_idx] <= jump_op.jumped;
                m_hist[train_idx] <= trained_counter(jump_op.prediction, jump_op.branched);
            end
            if (jump_valid && jump_op.update_pc) begin
                model_pc <= jump_op.actual_next_pc;
                model_epoch <= model_epoch + 2'd1;
            end else if (model_valid && cmd_ready && mem_ready) begin
                model_pc <= exp_next_pc;
            end
        end
    end

    // Random back-pressure with each ready high about three cycles in four
    always @(posedge clk) begin
        rnd = $random(seed);
        cmd_ready <= !backpressure || rnd[0] || rnd[1];
        mem_ready <= !backpressure || rnd[2] || rnd[3];
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Run stopped after %0d cycles without finishing", cycle));
        end
    end

    valid_low_in_reset: assert property (@(posedge clk)
        rst && cycle > 0 |-> !cmd_valid && !mem_valid
    ) else report_failure($sformatf("error: cmd_valid %h mem_valid %h in reset",
        cmd_valid, mem_valid));

    start_after_reset: assert property (@(posedge clk)
        !rst && $past(rst) |=> cmd_valid && mem_valid && cmd.pc == START_ADDR &&
            mem_addr == START_ADDR && cmd.jump_flag == 2'd0
    ) else report_failure($sformatf("error: cmd.pc %h jump_flag %h after reset, expected %h 0",
        cmd.pc, cmd.jump_flag, START_ADDR));

    valid_match: assert property (@(posedge clk) disable iff (rst)
        cmd_valid == model_valid && mem_valid == model_valid
    ) else report_failure($sformatf("error: cmd_valid %h mem_valid %h expected %h",
        cmd_valid, mem_valid, model_valid));

    pc_match: assert property (@(posedge clk) disable iff (rst)
        model_valid |-> cmd.pc == model_pc && mem_addr == model_pc
    ) else report_failure($sformatf("error: cmd.pc %h mem_addr %h expected %h",
        cmd.pc, mem_addr, model_pc));

    epoch_match: assert property (@(posedge clk) disable iff (rst)
        model_valid |-> cmd.jump_flag == model_epoch
    ) else report_failure($sformatf("error: cmd.jump_flag %h expected %h",
        cmd.jump_flag, model_epoch));

    miss_match: assert property (@(posedge clk) disable iff (rst)
        model_valid |-> cmd.prediction.miss == !exp_hit
    ) else report_failure($sformatf("error: cmd.prediction.miss %h expected %h at pc %h",
        cmd.prediction.miss, !exp_hit, model_pc));

    history_match: assert property (@(posedge clk) disable iff (rst)
        model_valid && exp_hit |-> cmd.prediction.history == exp_hist
    ) else report_failure($sformatf("error: cmd.prediction.history %h expected %h",
        cmd.prediction.history, exp_hist));

    next_pc_match: assert property (@(posedge clk) disable iff (rst)
        model_valid |-> cmd.next_pc == exp_next_pc
    ) else report_failure($sformatf("error: cmd.next_pc %h expected %h",
        cmd.next_pc, exp_next_pc));

    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !(cmd_ready && mem_ready) && !jump_valid |=>
            $stable(cmd) && $stable(mem_addr)
    ) else report_failure($sformatf("error: cmd.pc %h mem_addr %h changed during a stall",
        cmd.pc, mem_addr));

    redirect_applied: assert property (@(posedge clk) disable iff (rst)
        jump_valid && jump_op.update_pc |=> cmd.pc == $past(jump_op.actual_next_pc) &&
            cmd.jump_flag == $past(cmd.jump_flag) + 2'd1
    ) else report_failure($sformatf("error: cmd.pc %h jump_flag %h after redirect",
        cmd.pc, cmd.jump_flag));

    task automatic send_jump(input pc_t current, input pc_t actual, input logic update,
            input logic branched, input logic jumped, input prediction_t pred);
        jump_op_t op;
        op.current_pc = current;
        op.actual_next_pc = actual;
        op.update_pc = update;
        op.branched = branched;
        op.jumped = jumped;
        op.prediction = pred;
        @(posedge clk);
        jump_valid <= 1'b1;
        jump_op <= op;
        @(posedge clk);
        jump_valid <= 1'b0;
    endtask

    // Returns the prediction of the command accepted at this pc
    task automatic wait_fetch(input pc_t pc, output prediction_t pred);
        do begin
            @(posedge clk);
        end while (!(cmd_valid && cmd_ready && mem_ready && cmd.pc == pc));
        pred = cmd.prediction;
    endtask

    task automatic fetch_at(input pc_t pc, output prediction_t pred);
        send_jump(REDIRECT_SRC, pc, 1'b1, 1'b1, 1'b1, MISS_PRED);
        wait_fetch(pc, pred);
    endtask

    initial begin
        prediction_t pred;
        clk = 1'b0;
        rst = 1'b1;
        jump_valid = 1'b0;
        jump_op = '0;
        cmd_ready = 1'b0;
        mem_ready = 1'b0;
        backpressure = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        backpressure <= 1'b1;
        // Sequential fetch with an empty table
        repeat (60) @(posedge clk);
        fetch_at(32'h0000_1200, pred);
        repeat (20) @(posedge clk);
        // Branch trained taken once and then reported not taken twice
        send_jump(BRANCH_PC, BRANCH_TARGET, 1'b0, 1'b1, 1'b0, MISS_PRED);
        fetch_at(BRANCH_PC, pred);
        send_jump(BRANCH_PC, BRANCH_PC + 32'd4, 1'b1, 1'b0, 1'b0, pred);
        fetch_at(BRANCH_PC, pred);
        send_jump(BRANCH_PC, BRANCH_PC + 32'd4, 1'b0, 1'b0, 1'b0, pred);
        fetch_at(BRANCH_PC, pred);
        repeat (10) @(posedge clk);
        // Unconditional jump whose target aliases the branch entry
        // Its counter reads not taken so only the jump bit steers fetch to the target
        send_jump(JUMP_PC, JUMP_TARGET, 1'b0, 1'b0, 1'b1, MISS_PRED);
        fetch_at(JUMP_PC, pred);
        wait_fetch(JUMP_TARGET, pred);
        repeat (40) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- tb.f
hw/fetch_pkg.sv
hw/pred_ram.sv
hw/target_table.sv
hw/history_table.sv
hw/fetch_sequencer.sv
hw/fetch_unit.sv
sim/fetch_tb.sv
